//--- hw/uart_apb_regs.sv
// uart APB slave with DATA, STATUS and BAUD registers, FIFO strobes and sticky error flags.
`timescale 1ns/1ns

module uart_apb_regs (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [uart_pkg::ADDR_W-1:0]  paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [uart_pkg::PDATA_W-1:0] pwdata_i,
    output logic [uart_pkg::PDATA_W-1:0] prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    input  logic                         tx_full_i,
    input  logic                         tx_empty_i,
    input  uart_pkg::rx_entry_t          rx_head_i,
    input  logic                         rx_empty_i,
    input  logic                         rx_full_i,
    input  logic                         rx_push_i,
    input  logic                         rx_frame_err_i,
    output logic                         tx_push_o,
    output logic [uart_pkg::DATA_W-1:0]  tx_data_o,
    output logic                         rx_pop_o,
    output logic                         rx_push_o,
    output logic [uart_pkg::BAUD_W-1:0]  divisor_o
);
    import uart_pkg::*;

    logic              access;
    logic              wr;
    logic              rd;
    logic              sel_data;
    logic              sel_status;
    logic              sel_baud;
    logic              bad_addr;
    logic [BAUD_W-1:0] divisor_q;
    logic              rx_overrun_q;
    logic              frame_seen_q;
    status_t           status;
    status_t           wr_status;

    assign access     = psel_i && penable_i; // access phase only.
    assign wr         = access && pwrite_i;
    assign rd         = access && !pwrite_i;
    assign sel_data   = (paddr_i == ADDR_DATA);
    assign sel_status = (paddr_i == ADDR_STATUS);
    assign sel_baud   = (paddr_i == ADDR_BAUD);
    assign bad_addr   = !(sel_data || sel_status || sel_baud);

    assign pready_o  = penable_i; // no wait states.
    assign pslverr_o = access && (bad_addr
                                  || (wr && sel_data && tx_full_i)
                                  || (rd && sel_data && rx_empty_i));

    assign tx_push_o = wr && sel_data && !tx_full_i;
    assign tx_data_o = pwdata_i[DATA_W-1:0];
    assign rx_pop_o  = rd && sel_data && !rx_empty_i;
    assign rx_push_o = rx_push_i && !rx_full_i; // entry dropped when full.
    assign divisor_o = divisor_q;

    assign status = '{frame_seen: frame_seen_q,
                      rx_overrun: rx_overrun_q,
                      rx_empty:   rx_empty_i,
                      tx_empty:   tx_empty_i,
                      tx_full:    tx_full_i};
    assign wr_status = status_t'(pwdata_i[$bits(status_t)-1:0]);

    always_comb begin
        prdata_o = '0;
        if (rd) begin
            if (sel_data && !rx_empty_i) begin
                prdata_o = PDATA_W'(rx_head_i);
            end else if (sel_status) begin
                prdata_o = PDATA_W'(status);
            end else if (sel_baud) begin
                prdata_o = PDATA_W'(divisor_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            divisor_q    <= BAUD_RESET;
            rx_overrun_q <= 1'b0;
            frame_seen_q <= 1'b0;
        end else begin
            if (wr && sel_baud) begin
                divisor_q <= pwdata_i[BAUD_W-1:0];
            end
            if (wr && sel_status && wr_status.rx_overrun) begin
                rx_overrun_q <= 1'b0;
            end
            if (wr && sel_status && wr_status.frame_seen) begin
                frame_seen_q <= 1'b0;
            end
            if (rx_push_i && rx_full_i) begin
                rx_overrun_q <= 1'b1; // a new event beats a clear.
            end
            if (rx_push_i && rx_frame_err_i) begin
                frame_seen_q <= 1'b1;
            end
        end
    end

endmodule

//--- hw/uart_fifo.sv
// uart FIFO, a show-ahead synchronous circular buffer with a typed payload.
`timescale 1ns/1ns

module uart_fifo #(
    parameter type T     = logic [uart_pkg::DATA_W-1:0],
    parameter int  DEPTH = uart_pkg::FIFO_DEPTH
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic push_i,
    input  T     push_data_i,
    input  logic pop_i,
    output T     head_o,
    output logic full_o,
    output logic empty_o
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full_o || do_pop); // full plus pop frees a slot.
    assign head_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- hw/uart_pkg.sv
// uart package with the shared widths, register map, reset values and payload types.
package uart_pkg;

    localparam int DATA_W     = 8;
    localparam int BAUD_W     = 16;
    localparam int ADDR_W     = 8;
    localparam int PDATA_W    = 32;
    localparam int FIFO_DEPTH = 4;

    localparam logic [BAUD_W-1:0] BAUD_RESET = 16'd15; // 16 cycles per bit.

    localparam logic [ADDR_W-1:0] ADDR_DATA   = 8'h0;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 8'h4;
    localparam logic [ADDR_W-1:0] ADDR_BAUD   = 8'h8;

    // shared by the transmitter and receiver FSMs.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } uart_state_e;

    typedef struct packed {
        logic              frame_err; // stop bit sampled low.
        logic [DATA_W-1:0] data;
    } rx_entry_t;

    typedef struct packed {
        logic frame_seen;  // sticky bit 4.
        logic rx_overrun;  // sticky bit 3.
        logic rx_empty;
        logic tx_empty;
        logic tx_full;
    } status_t;

endpackage

//--- hw/uart_rx.sv
// uart receiver that synchronizes the line, samples mid-bit and emits one entry per frame.
`timescale 1ns/1ns

module uart_rx (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        rx_i,
    input  logic [uart_pkg::BAUD_W-1:0] divisor_i,
    output logic                        push_o,
    output uart_pkg::rx_entry_t         entry_o
);
    import uart_pkg::*;

    logic [1:0]        sync_q;
    logic              rx_prev_q;
    logic              rx_s;
    logic              fall;
    uart_state_e       state_q;
    logic [BAUD_W-1:0] baud_cnt_q;
    logic [2:0]        bit_idx_q;
    logic [DATA_W-1:0] shift_q;
    logic              half_done;
    logic              bit_done;

    assign rx_s      = sync_q[1];
    assign fall      = rx_prev_q && !rx_s;
    assign half_done = (baud_cnt_q >= (divisor_i >> 1));
    assign bit_done  = (baud_cnt_q >= divisor_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync_q    <= 2'b11; // line idles high.
            rx_prev_q <= 1'b1;
        end else begin
            sync_q    <= {sync_q[0], rx_i};
            rx_prev_q <= rx_s;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            push_o     <= 1'b0;
        end else begin
            push_o     <= 1'b0;
            baud_cnt_q <= baud_cnt_q + 1'b1;
            case (state_q)
                ST_IDLE: begin
                    baud_cnt_q <= '0;
                    bit_idx_q  <= '0;
                    if (fall) begin
                        state_q <= ST_START;
                    end
                end
                ST_START: begin
                    if (half_done) begin
                        baud_cnt_q <= '0;
                        state_q    <= rx_s ? ST_IDLE : ST_DATA; // high here is a glitch.
                    end
                end
                ST_DATA: begin
                    if (bit_done) begin
                        baud_cnt_q <= '0;
                        bit_idx_q  <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (bit_done) begin
                        baud_cnt_q <= '0;
                        state_q    <= ST_IDLE;
                        push_o     <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_DATA && bit_done) begin
            shift_q <= {rx_s, shift_q[DATA_W-1:1]}; // lsb arrives first.
        end
        if (state_q == ST_STOP && bit_done) begin
            entry_o.data      <= shift_q;
            entry_o.frame_err <= !rx_s;
        end
    end

endmodule

//--- hw/uart_top.sv
// uart top level joining the APB slave, both FIFOs, the transmitter and the receiver.
`timescale 1ns/1ns

module uart_top (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [uart_pkg::ADDR_W-1:0]  paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [uart_pkg::PDATA_W-1:0] pwdata_i,
    input  logic                         rx_i,
    output logic [uart_pkg::PDATA_W-1:0] prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    output logic                         tx_o
);
    import uart_pkg::*;

    logic              tx_push;
    logic [DATA_W-1:0] tx_data;
    logic [DATA_W-1:0] tx_head;
    logic              tx_full;
    logic              tx_empty;
    logic              tx_ready;
    logic              rx_push_raw;
    rx_entry_t         rx_entry;
    logic              rx_push;
    logic              rx_pop;
    rx_entry_t         rx_head;
    logic              rx_full;
    logic              rx_empty;
    logic [BAUD_W-1:0] divisor;

    uart_apb_regs u_regs (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .paddr_i        (paddr_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .tx_full_i      (tx_full),
        .tx_empty_i     (tx_empty),
        .rx_head_i      (rx_head),
        .rx_empty_i     (rx_empty),
        .rx_full_i      (rx_full),
        .rx_push_i      (rx_push_raw),
        .rx_frame_err_i (rx_entry.frame_err),
        .tx_push_o      (tx_push),
        .tx_data_o      (tx_data),
        .rx_pop_o       (rx_pop),
        .rx_push_o      (rx_push),
        .divisor_o      (divisor)
    );

    uart_fifo #(.T(logic [DATA_W-1:0]), .DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (tx_push),
        .push_data_i (tx_data),
        .pop_i       (tx_ready), // ignored while empty.
        .head_o      (tx_head),
        .full_o      (tx_full),
        .empty_o     (tx_empty)
    );

    uart_fifo #(.T(rx_entry_t), .DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (rx_push),
        .push_data_i (rx_entry),
        .pop_i       (rx_pop),
        .head_o      (rx_head),
        .full_o      (rx_full),
        .empty_o     (rx_empty)
    );

    uart_tx u_tx (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .data_i    (tx_head),
        .valid_i   (!tx_empty),
        .divisor_i (divisor),
        .ready_o   (tx_ready),
        .tx_o      (tx_o)
    );

    uart_rx u_rx (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rx_i      (rx_i),
        .divisor_i (divisor),
        .push_o    (rx_push_raw),
        .entry_o   (rx_entry)
    );

endmodule

//--- hw/uart_tx.sv
// uart transmitter FSM sending 8N1 frames, LSB first, at divisor+1 cycles per bit.
`timescale 1ns/1ns

module uart_tx (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [uart_pkg::DATA_W-1:0] data_i,
    input  logic                        valid_i,
    input  logic [uart_pkg::BAUD_W-1:0] divisor_i,
    output logic                        ready_o,
    output logic                        tx_o
);
    import uart_pkg::*;

    uart_state_e       state_q;
    logic [BAUD_W-1:0] baud_cnt_q;
    logic [2:0]        bit_idx_q;
    logic [DATA_W-1:0] shift_q;
    logic              bit_done;

    assign bit_done = (baud_cnt_q >= divisor_i);
    assign ready_o  = (state_q == ST_IDLE);

    always_comb begin
        case (state_q)
            ST_START: tx_o = 1'b0;
            ST_DATA:  tx_o = shift_q[0];
            default:  tx_o = 1'b1; // idle and stop.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
        end else begin
            baud_cnt_q <= bit_done ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                ST_IDLE: begin
                    baud_cnt_q <= '0;
                    bit_idx_q  <= '0;
                    if (valid_i) begin
                        state_q <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_done) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (bit_done) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (bit_done) begin
                        state_q <= ST_IDLE; // one idle cycle before next accept.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready_o && valid_i) begin
            shift_q <= data_i;
        end else if (state_q == ST_DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# compile with verilator, run, then decide the result from the simulation log.
verilator --binary --timing --top-module uart_tb -f src.f -o uart_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/uart_sim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || exit 1

//--- src.f
hw/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_apb_regs.sv
hw/uart_top.sv
verif/uart_tb.sv

//--- verif/uart_tb.sv
// uart testbench with serial loopback, a stimulus table and register, timing and FIFO checks.
`timescale 1ns/1ns

module uart_tb;
    import uart_pkg::*;

    localparam int NUM_ROWS  = 6;
    localparam int BURST_DIV = 15;

    logic               clk;
    logic               rst;
    logic [ADDR_W-1:0]  paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [PDATA_W-1:0] pwdata;
    logic [PDATA_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
    logic               tx;
    logic               rx;
    logic               corrupt;
    logic [BAUD_W-1:0]  row_div     [NUM_ROWS];
    logic [DATA_W-1:0]  row_byte    [NUM_ROWS];
    logic               row_corrupt [NUM_ROWS];
    logic [PDATA_W-1:0] row_exp     [NUM_ROWS];
    logic [31:0]        rng_state   = 32'h17edd04e;
    int                 cycles      = 0;
    int                 cycle_limit = 2000;
    int                 low_run     = 0;
    int                 last_low    = 0;

    assign rx = corrupt ? 1'b0 : tx; // loopback.

    uart_top dut (
        .clk_i     (clk),
        .rst_i     (rst),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .rx_i      (rx),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .tx_o      (tx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycles);
            $display("FAIL: see errors above");
            $fatal(1, "simulation timed out");
        end
    end

    // length of the most recent low run on tx_o.
    always @(negedge clk) begin
        if (!tx) begin
            low_run <= low_run + 1;
        end else if (low_run != 0) begin
            last_low <= low_run;
            low_run  <= 0;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [DATA_W-1:0] next_random_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[DATA_W-1:0];
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic set_row(input int idx, input logic [BAUD_W-1:0] div,
                           input logic [DATA_W-1:0] data, input logic bad);
        row_div[idx]     = div;
        row_byte[idx]    = data;
        row_corrupt[idx] = bad;
        row_exp[idx]     = {23'd0, bad, data}; // frame_err in bit 8.
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [PDATA_W-1:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check_equal(32'(pready), 32'd1, "pready in write access phase");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [PDATA_W-1:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_equal(32'(pready), 32'd1, "pready in read access phase");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_rx_data();
        logic [PDATA_W-1:0] rdata;
        logic               err;
        status_t            st;
        do begin
            apb_read(ADDR_STATUS, rdata, err);
            st = status_t'(rdata[4:0]);
        end while (st.rx_empty);
    endtask

    initial begin
        logic [PDATA_W-1:0] rdata;
        logic               err;
        logic [DATA_W-1:0]  burst [FIFO_DEPTH+1];
        status_t            st;
        status_t            exp_st;
        int                 d;

        rst     <= 1'b1;
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;
        corrupt <= 1'b0;
        set_row(0, 16'd15, 8'h80, 1'b0);
        set_row(1, 16'd3, 8'h80, 1'b0);
        set_row(2, 16'd7, next_random_byte(), 1'b0);
        set_row(3, 16'd3, next_random_byte(), 1'b0);
        set_row(4, 16'd15, next_random_byte(), 1'b1);
        set_row(5, 16'd15, next_random_byte(), 1'b0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += 12 * (int'(row_div[i]) + 1);
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        exp_st = '{frame_seen: 1'b0, rx_overrun: 1'b0, rx_empty: 1'b1,
                   tx_empty: 1'b1, tx_full: 1'b0};
        apb_read(ADDR_STATUS, rdata, err);
        check_equal(rdata, {27'd0, exp_st}, "STATUS after reset");
        apb_read(ADDR_BAUD, rdata, err);
        check_equal(rdata, {16'd0, BAUD_RESET}, "BAUD after reset");
        @(negedge clk);
        check_equal(32'(tx), 32'd1, "tx_o after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            d = int'(row_div[i]) + 1; // cycles per bit.
            apb_write(ADDR_BAUD, 32'(row_div[i]), err);
            apb_write(ADDR_DATA, 32'(row_byte[i]), err);
            check_equal(32'(err), 32'd0, "pslverr on DATA write");
            if (row_corrupt[i]) begin
                @(negedge clk);
                while (tx) @(negedge clk);
                repeat (9 * d) @(posedge clk);
                corrupt <= 1'b1; // stop bit held low.
                repeat (d) @(posedge clk);
                corrupt <= 1'b0;
            end
            wait_rx_data();
            apb_read(ADDR_DATA, rdata, err);
            check_equal(rdata, row_exp[i], "DATA read of table row");
            check_equal(32'(err), 32'd0, "pslverr on DATA read");
            if (row_byte[i] == 8'h80) begin
                check_equal(last_low, 8 * d, "tx_o low cycles for byte 0x80");
            end
            if (row_corrupt[i]) begin
                apb_read(ADDR_STATUS, rdata, err);
                st = status_t'(rdata[4:0]);
                check_equal(32'(st.frame_seen), 32'd1, "frame_seen after bad stop bit");
                apb_write(ADDR_STATUS, 32'h10, err);
                apb_read(ADDR_STATUS, rdata, err);
                st = status_t'(rdata[4:0]);
                check_equal(32'(st.frame_seen), 32'd0, "frame_seen after clear");
            end
        end

        apb_write(ADDR_BAUD, 32'(BURST_DIV), err);
        for (int k = 0; k <= FIFO_DEPTH; k++) begin
            burst[k] = next_random_byte();
            apb_write(ADDR_DATA, 32'(burst[k]), err);
            check_equal(32'(err), 32'd0, "pslverr on burst write");
        end
        apb_write(ADDR_DATA, 32'(next_random_byte()), err);
        check_equal(32'(err), 32'd1, "pslverr on write to full tx FIFO");
        repeat ((2 * FIFO_DEPTH + 2) * 10 * (BURST_DIV + 1)) @(posedge clk);
        exp_st = '{frame_seen: 1'b0, rx_overrun: 1'b1, rx_empty: 1'b0,
                   tx_empty: 1'b1, tx_full: 1'b0};
        apb_read(ADDR_STATUS, rdata, err);
        check_equal(rdata, {27'd0, exp_st}, "STATUS after rx FIFO overrun");
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            apb_read(ADDR_DATA, rdata, err);
            check_equal(rdata, {24'd0, burst[k]}, "burst byte read order");
            check_equal(32'(err), 32'd0, "pslverr on burst read");
        end

        apb_read(ADDR_DATA, rdata, err);
        check_equal(rdata, 32'd0, "DATA read with rx FIFO empty");
        check_equal(32'(err), 32'd1, "pslverr on empty DATA read");
        apb_write(8'hC, 32'h1, err);
        check_equal(32'(err), 32'd1, "pslverr on unmapped offset");

        $display("PASS: all tests");
        $finish;
    end

endmodule
